// File: include/mem_bus_consts.svh
`ifndef MEM_BUS_CONSTS_SVH
`define MEM_BUS_CONSTS_SVH

// masters sharing the memory
`define MB_N_MASTERS 3

// 256 words of 32 bits
`define MB_ADDR_W 8
`define MB_DATA_W 32

`define MB_WAIT_STATES 2 // default access phase wait cycles

`endif

// File: rtl/mem_bus_pkg.sv
`default_nettype none

`include "mem_bus_consts.svh"

package mem_bus_pkg;

    // one bit per master, used for request and grant
    typedef logic [`MB_N_MASTERS-1:0] master_vec_t;

    typedef logic [`MB_ADDR_W-1:0] addr_t; // word address
    typedef logic [`MB_DATA_W-1:0] data_t;

    typedef enum logic {
        READY,
        BUSY
    } arb_state_t;

endpackage

`default_nettype wire

// File: rtl/apb_if.sv
`timescale 1ns/1ps
`default_nettype none

interface apb_if;

    mem_bus_pkg::addr_t paddr;
    logic               psel;
    logic               penable;
    logic               pwrite;
    mem_bus_pkg::data_t pwdata;
    mem_bus_pkg::data_t prdata;
    logic               pready;

    modport requester (
        output paddr, psel, penable, pwrite, pwdata,
        input  prdata, pready
    );

    modport completer (
        input  paddr, psel, penable, pwrite, pwdata,
        output prdata, pready
    );

endinterface

`default_nettype wire

// File: rtl/port_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module port_bridge (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     psel,
    input  wire                     penable,
    input  wire                     pwrite,
    input  wire mem_bus_pkg::addr_t paddr,
    input  wire mem_bus_pkg::data_t pwdata,
    output mem_bus_pkg::data_t      prdata,
    output logic                    pready,
    output logic                    req,
    input  wire                     grant,
    apb_if.requester                bus
);

    typedef enum logic [2:0] {IDLE, WAIT_GRANT, SETUP, ACCESS, DONE} state_t;

    state_t             state;
    logic               start;
    logic               finish;
    logic               write_q;
    mem_bus_pkg::addr_t addr_q;
    mem_bus_pkg::data_t wdata_q;
    mem_bus_pkg::data_t rdata_q;

    assign start  = (state == IDLE) && psel && !penable; // external setup phase
    assign finish = (state == ACCESS) && bus.pready;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= IDLE;
            req   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state <= WAIT_GRANT;
                        req   <= 1'b1;
                    end
                end
                WAIT_GRANT: begin
                    if (grant) state <= SETUP;
                end
                SETUP: state <= ACCESS;
                ACCESS: begin
                    if (finish) begin
                        state <= DONE;
                        req   <= 1'b0;
                    end
                end
                default: state <= IDLE; // DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            write_q <= pwrite;
            addr_q  <= paddr;
            wdata_q <= pwdata;
        end
        if (finish) rdata_q <= bus.prdata;
    end

    assign bus.psel    = (state == SETUP) || (state == ACCESS);
    assign bus.penable = (state == ACCESS);
    assign bus.pwrite  = write_q;
    assign bus.paddr   = addr_q;
    assign bus.pwdata  = wdata_q;

    assign prdata = rdata_q;
    assign pready = (state == DONE);

endmodule

`default_nettype wire

// File: rtl/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_consts.svh"

module bus_arbiter (
    input  wire                      clk,
    input  wire                      reset,
    input  wire mem_bus_pkg::master_vec_t req,
    output mem_bus_pkg::master_vec_t grant,
    apb_if.completer                 bridge_bus [`MB_N_MASTERS],
    apb_if.requester                 shared_bus
);

    mem_bus_pkg::arb_state_t  state;
    mem_bus_pkg::master_vec_t candidates;
    mem_bus_pkg::master_vec_t pick;
    logic                     done;

    logic [`MB_N_MASTERS-1:0] leg_psel;
    logic [`MB_N_MASTERS-1:0] leg_penable;
    logic [`MB_N_MASTERS-1:0] leg_pwrite;
    mem_bus_pkg::addr_t       leg_paddr  [`MB_N_MASTERS];
    mem_bus_pkg::data_t       leg_pwdata [`MB_N_MASTERS];

    // unpack the bridge legs so the mux below can index them
    for (genvar g = 0; g < `MB_N_MASTERS; g++) begin : g_leg
        assign leg_psel[g]    = bridge_bus[g].psel;
        assign leg_penable[g] = bridge_bus[g].penable;
        assign leg_pwrite[g]  = bridge_bus[g].pwrite;
        assign leg_paddr[g]   = bridge_bus[g].paddr;
        assign leg_pwdata[g]  = bridge_bus[g].pwdata;

        assign bridge_bus[g].prdata = shared_bus.prdata;
        assign bridge_bus[g].pready = shared_bus.pready && grant[g]; // only the owner completes
    end

    assign done = shared_bus.psel && shared_bus.penable && shared_bus.pready;

    // the master that just finished must not win again straight away
    assign candidates = req & ~grant;

    always_comb begin
        pick = '0;
        for (int i = `MB_N_MASTERS - 1; i >= 0; i--) begin
            if (candidates[i]) begin
                pick    = '0;
                pick[i] = 1'b1; // lower index overwrites higher
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= mem_bus_pkg::READY;
            grant <= '0;
        end else begin
            case (state)
                mem_bus_pkg::READY: begin
                    if (|req) begin
                        grant <= pick;
                        state <= mem_bus_pkg::BUSY;
                    end
                end
                mem_bus_pkg::BUSY: begin
                    if (done) begin
                        grant <= pick; // hand over at the completion edge
                        state <= (|pick) ? mem_bus_pkg::BUSY : mem_bus_pkg::READY;
                    end
                end
                default: begin
                    grant <= '0;
                    state <= mem_bus_pkg::READY;
                end
            endcase
        end
    end

    always_comb begin
        shared_bus.psel    = 1'b0;
        shared_bus.penable = 1'b0;
        shared_bus.pwrite  = 1'b0;
        shared_bus.paddr   = '0;
        shared_bus.pwdata  = '0;
        for (int i = 0; i < `MB_N_MASTERS; i++) begin
            if (grant[i]) begin
                shared_bus.psel    = leg_psel[i];
                shared_bus.penable = leg_penable[i];
                shared_bus.pwrite  = leg_pwrite[i];
                shared_bus.paddr   = leg_paddr[i];
                shared_bus.pwdata  = leg_pwdata[i];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/wait_state_mem.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_consts.svh"

module wait_state_mem #(
    parameter int WAIT_STATES = `MB_WAIT_STATES
) (
    input  wire      clk,
    input  wire      reset,
    apb_if.completer bus
);

    localparam int DEPTH = 2 ** `MB_ADDR_W;
    localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

    mem_bus_pkg::data_t mem [DEPTH];
    logic [CNT_W-1:0]   wait_cnt;
    logic               access;
    logic               ready;

    assign access = bus.psel && bus.penable;
    assign ready  = access && (wait_cnt == CNT_W'(WAIT_STATES));

    // counts access phase cycles until the last wait state has passed
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wait_cnt <= '0;
        end else if (access && !ready) begin
            wait_cnt <= wait_cnt + CNT_W'(1);
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (ready && bus.pwrite) begin
            mem[bus.paddr] <= bus.pwdata; // commit on the completion edge
        end
    end

    assign bus.pready = ready;
    assign bus.prdata = mem[bus.paddr];

endmodule

`default_nettype wire

// File: rtl/shared_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_consts.svh"

module shared_mem_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     m0_psel,
    input  wire                     m0_penable,
    input  wire                     m0_pwrite,
    input  wire mem_bus_pkg::addr_t m0_paddr,
    input  wire mem_bus_pkg::data_t m0_pwdata,
    output wire mem_bus_pkg::data_t m0_prdata,
    output wire                     m0_pready,
    input  wire                     m1_psel,
    input  wire                     m1_penable,
    input  wire                     m1_pwrite,
    input  wire mem_bus_pkg::addr_t m1_paddr,
    input  wire mem_bus_pkg::data_t m1_pwdata,
    output wire mem_bus_pkg::data_t m1_prdata,
    output wire                     m1_pready,
    input  wire                     m2_psel,
    input  wire                     m2_penable,
    input  wire                     m2_pwrite,
    input  wire mem_bus_pkg::addr_t m2_paddr,
    input  wire mem_bus_pkg::data_t m2_pwdata,
    output wire mem_bus_pkg::data_t m2_prdata,
    output wire                     m2_pready
);

    wire mem_bus_pkg::master_vec_t req;
    wire mem_bus_pkg::master_vec_t grant;

    apb_if bridge_bus [`MB_N_MASTERS] ();
    apb_if shared_bus ();

    port_bridge u_bridge0 (
        .clk(clk), .reset(reset),
        .psel(m0_psel), .penable(m0_penable), .pwrite(m0_pwrite),
        .paddr(m0_paddr), .pwdata(m0_pwdata),
        .prdata(m0_prdata), .pready(m0_pready),
        .req(req[0]), .grant(grant[0]),
        .bus(bridge_bus[0])
    );

    port_bridge u_bridge1 (
        .clk(clk), .reset(reset),
        .psel(m1_psel), .penable(m1_penable), .pwrite(m1_pwrite),
        .paddr(m1_paddr), .pwdata(m1_pwdata),
        .prdata(m1_prdata), .pready(m1_pready),
        .req(req[1]), .grant(grant[1]),
        .bus(bridge_bus[1])
    );

    port_bridge u_bridge2 (
        .clk(clk), .reset(reset),
        .psel(m2_psel), .penable(m2_penable), .pwrite(m2_pwrite),
        .paddr(m2_paddr), .pwdata(m2_pwdata),
        .prdata(m2_prdata), .pready(m2_pready),
        .req(req[2]), .grant(grant[2]),
        .bus(bridge_bus[2])
    );

    bus_arbiter u_arbiter (
        .clk(clk), .reset(reset),
        .req(req), .grant(grant),
        .bridge_bus(bridge_bus),
        .shared_bus(shared_bus)
    );

    wait_state_mem #(.WAIT_STATES(`MB_WAIT_STATES)) u_mem (
        .clk(clk), .reset(reset),
        .bus(shared_bus)
    );

endmodule

`default_nettype wire

// File: tb/shared_mem_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_bus_consts.svh"

module shared_mem_tb;

    localparam int CLK_NS       = 40;
    localparam int N_TRANSFERS  = 73; // 6 single, 4 priority, 3 no preempt, 60 random
    localparam int XFER_CYCLES  = 20;
    localparam int WATCHDOG_NS  = (N_TRANSFERS * XFER_CYCLES + 100) * CLK_NS;
    localparam int PREADY_LIMIT = 40 * XFER_CYCLES; // m2 can starve until m0 and m1 run dry
    localparam int DEPTH        = 2 ** `MB_ADDR_W;

    logic                     clk;
    logic                     reset;
    logic [2:0]               psel;
    logic [2:0]               penable;
    logic [2:0]               pwrite;
    mem_bus_pkg::addr_t       paddr  [3];
    mem_bus_pkg::data_t       pwdata [3];
    wire mem_bus_pkg::data_t  prdata [3];
    wire [2:0]                pready;

    mem_bus_pkg::data_t model [DEPTH]; // what every write should have stored
    bit                 valid [DEPTH];
    time                done_at [3];

    shared_mem_top dut (
        .clk(clk), .reset(reset),
        .m0_psel(psel[0]), .m0_penable(penable[0]), .m0_pwrite(pwrite[0]),
        .m0_paddr(paddr[0]), .m0_pwdata(pwdata[0]),
        .m0_prdata(prdata[0]), .m0_pready(pready[0]),
        .m1_psel(psel[1]), .m1_penable(penable[1]), .m1_pwrite(pwrite[1]),
        .m1_paddr(paddr[1]), .m1_pwdata(pwdata[1]),
        .m1_prdata(prdata[1]), .m1_pready(pready[1]),
        .m2_psel(psel[2]), .m2_penable(penable[2]), .m2_pwrite(pwrite[2]),
        .m2_paddr(paddr[2]), .m2_pwdata(pwdata[2]),
        .m2_prdata(prdata[2]), .m2_pready(pready[2])
    );

    always #(CLK_NS / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // samples pready at the falling edge, where it is stable
    task automatic wait_pready(input int k);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (pready[k] !== 1'b1) begin
            if (cycles == PREADY_LIMIT) begin
                $display("master %0d got no pready within %0d cycles", k, PREADY_LIMIT);
                $display("Test failures found");
                $fatal(1);
            end
            cycles++;
            @(negedge clk);
        end
        done_at[k] = $time;
    endtask

    task automatic apb_write(input int k, input mem_bus_pkg::addr_t addr,
                             input mem_bus_pkg::data_t data);
        @(posedge clk);
        #2;
        psel[k]    = 1'b1; // setup phase
        penable[k] = 1'b0;
        pwrite[k]  = 1'b1;
        paddr[k]   = addr;
        pwdata[k]  = data;
        @(posedge clk);
        #2;
        penable[k] = 1'b1;
        wait_pready(k);
        @(posedge clk);
        #2;
        psel[k]    = 1'b0;
        penable[k] = 1'b0;
    endtask

    task automatic apb_read(input int k, input mem_bus_pkg::addr_t addr,
                            output mem_bus_pkg::data_t data);
        @(posedge clk);
        #2;
        psel[k]    = 1'b1;
        penable[k] = 1'b0;
        pwrite[k]  = 1'b0;
        paddr[k]   = addr;
        @(posedge clk);
        #2;
        penable[k] = 1'b1;
        wait_pready(k);
        data = prdata[k]; // registered by the bridge, valid with pready
        @(posedge clk);
        #2;
        psel[k]    = 1'b0;
        penable[k] = 1'b0;
    endtask

    task automatic test_reset_idle();
        repeat (4) begin
            @(negedge clk);
            check("test_reset_idle", 32'h0, {29'h0, pready});
        end
        @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (4) begin
            @(negedge clk);
            check("test_reset_idle", 32'h0, {29'h0, pready});
        end
    endtask

    task automatic test_single_master();
        mem_bus_pkg::data_t rd;
        mem_bus_pkg::addr_t a;
        for (int k = 0; k < 3; k++) begin
            a = 8'h30 + 8'(k);
            apb_write(k, a, 32'h5a00_0000 + 32'(k * 32'h0101_0101));
            model[a] = 32'h5a00_0000 + 32'(k * 32'h0101_0101);
            apb_read(k, a, rd);
            check("test_single_master", model[a], rd);
        end
    endtask

    task automatic test_priority_order();
        mem_bus_pkg::data_t rd;
        fork
            apb_write(0, 8'hf0, 32'haaaa_0000);
            apb_write(1, 8'hf0, 32'hbbbb_1111);
            apb_write(2, 8'hf0, 32'hcccc_2222);
        join
        check("test_priority_order", 32'h1, {31'h0, done_at[0] < done_at[1]});
        check("test_priority_order", 32'h1, {31'h0, done_at[1] < done_at[2]});
        model[8'hf0] = 32'hcccc_2222; // m2 finishes last
        apb_read(0, 8'hf0, rd);
        check("test_priority_order", model[8'hf0], rd);
    endtask

    task automatic test_no_preempt();
        mem_bus_pkg::data_t rd;
        fork
            apb_write(2, 8'he0, 32'h2222_e0e0);
            begin
                @(posedge clk); // m0 starts one cycle after m2's setup
                apb_write(0, 8'he0, 32'h0000_e0e0);
            end
        join
        check("test_no_preempt", 32'h1, {31'h0, done_at[2] < done_at[0]});
        model[8'he0] = 32'h0000_e0e0;
        apb_read(1, 8'he0, rd);
        check("test_no_preempt", model[8'he0], rd);
    endtask

    // each master stays in its own address region so the model is exact
    task automatic random_master_traffic(input int k, input int n_ops);
        mem_bus_pkg::addr_t a;
        mem_bus_pkg::data_t d;
        mem_bus_pkg::data_t rd;
        for (int i = 0; i < n_ops; i++) begin
            a = {k[1:0], 3'b000, 3'($urandom)};
            if ($urandom_range(1, 0) == 1 && valid[a]) begin
                apb_read(k, a, rd);
                check("test_random_traffic", model[a], rd);
            end else begin
                d = $urandom;
                apb_write(k, a, d);
                model[a] = d;
                valid[a] = 1'b1;
            end
        end
    endtask

    task automatic test_random_traffic();
        fork
            random_master_traffic(0, 20);
            random_master_traffic(1, 20);
            random_master_traffic(2, 20);
        join
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $fatal(1);
    end

    initial begin
        void'($urandom(32'hc7b3));
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = '0;
        penable = '0;
        pwrite  = '0;
        for (int k = 0; k < 3; k++) begin
            paddr[k]  = '0;
            pwdata[k] = '0;
        end
        test_reset_idle();
        test_single_master();
        test_priority_order();
        test_no_preempt();
        test_random_traffic();
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
rtl/mem_bus_pkg.sv
rtl/apb_if.sv
rtl/port_bridge.sv
rtl/bus_arbiter.sv
rtl/wait_state_mem.sv
rtl/shared_mem_top.sv
tb/shared_mem_tb.sv
